// ==== logic/converge_pkg.sv ====
package converge_pkg;

    ///////////////////////////////
    // Sizes
    ///////////////////////////////

    localparam int NUM_PORTS      = 7;
    localparam int PORT_BITS      = 3;
    localparam int SRC_PORT_BITS  = 4;
    localparam int FIFO_ADDR_BITS = 4;
    localparam int FIFO_DEPTH     = 1 << FIFO_ADDR_BITS;
    localparam int PAYLOAD_BITS   = 26;

    // Highest port index, where the poll and scan pointers wrap
    localparam logic [PORT_BITS-1:0] LAST_PORT = PORT_BITS'(NUM_PORTS - 1);

    ///////////////////////////////
    // Packet format
    ///////////////////////////////

    typedef enum logic [1:0] {
        KIND_DATA,
        KIND_FREESPACE,
        KIND_CTRL
    } pkt_kind_e;

    // Valid sits in the top bit
    typedef struct packed {
        logic                     valid;
        pkt_kind_e                kind;
        logic [SRC_PORT_BITS-1:0] src_port;
        logic [PAYLOAD_BITS-1:0]  payload;
    } packet_t;

    ///////////////////////////////
    // Stage to stage
    ///////////////////////////////

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_PASS_FIFO,
        OP_PASS_PORT,
        OP_CAPTURE_FIFO,
        OP_CAPTURE_PORT,
        OP_HOLD,
        OP_RELEASE
    } stream_op_e;

    typedef struct packed {
        logic    en;
        packet_t data;
    } fifo_wr_t;

    typedef struct packed {
        stream_op_e           op;
        logic [PORT_BITS-1:0] port;
    } stream_cmd_t;

endpackage

// ==== logic/update_decode.sv ====
`timescale 1ns/100ps

module update_decode (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [converge_pkg::NUM_PORTS-1:0]      freespace_update_i,
    input  converge_pkg::packet_t                   in_packets_i [converge_pkg::NUM_PORTS],
    output converge_pkg::fifo_wr_t                  fifo_wr_o
);

    // Strobe levels of the previous cycle
    logic [converge_pkg::NUM_PORTS-1:0] strobe_q;
    logic [converge_pkg::NUM_PORTS-1:0] rise;

    // One pending update per input port
    converge_pkg::packet_t slots [converge_pkg::NUM_PORTS];

    logic [converge_pkg::PORT_BITS-1:0] scan_ptr;
    logic [converge_pkg::NUM_PORTS-1:0] slot_clear;
    logic                               scan_hit;

    // A held strobe only counts on its first cycle
    assign rise = freespace_update_i & ~strobe_q;

    ///////////////////////////////
    // Scan
    ///////////////////////////////

    always_comb begin
        scan_hit = slots[scan_ptr].valid;
        slot_clear = '0;
        slot_clear[scan_ptr] = scan_hit;
        fifo_wr_o.en = scan_hit;
        if (scan_hit) begin
            fifo_wr_o.data = slots[scan_ptr];
        end else begin
            fifo_wr_o.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_q <= '0;
            scan_ptr <= '0;
        end else begin
            strobe_q <= freespace_update_i;
            if (scan_ptr == converge_pkg::LAST_PORT) begin
                scan_ptr <= '0;
            end else begin
                scan_ptr <= scan_ptr + 1'b1;
            end
        end
    end

    ///////////////////////////////
    // Slots
    ///////////////////////////////

    // New edge wins over the scan clear, so a full slot is overwritten
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
                slots[i] <= '0;
            end
        end else begin
            for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
                if (rise[i]) begin
                    // Packet with valid low leaves the slot empty
                    slots[i] <= in_packets_i[i];
                end else if (slot_clear[i]) begin
                    slots[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== logic/update_fifo.sv ====
`timescale 1ns/100ps

module update_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  converge_pkg::fifo_wr_t wr_i,
    input  logic                   pop_i,
    output logic                   empty_o,
    output converge_pkg::packet_t  rd_data_o
);

    converge_pkg::packet_t mem [converge_pkg::FIFO_DEPTH];

    logic [converge_pkg::FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [converge_pkg::FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [converge_pkg::FIFO_ADDR_BITS:0]   count;
    logic                                    do_pop;

    assign empty_o = (count == '0);

    // Pop on empty is ignored
    assign do_pop = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_ptr] <= wr_i.data;
        end
    end

    // Head shows up on rd_data_o the cycle after the pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_i.en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_i.en, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/converge_execute.sv ====
`timescale 1ns/100ps

module converge_execute (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               resend_i,
    input  logic                               fifo_empty_i,
    output logic                               pop_o,
    output logic [converge_pkg::NUM_PORTS-1:0] outport_sel_o,
    output converge_pkg::stream_cmd_t          cmd_o
);

    logic                               resend_q;
    logic                               stall;
    logic                               poll;
    logic [converge_pkg::PORT_BITS-1:0] poll_ptr;
    logic [converge_pkg::NUM_PORTS-1:0] sel_one;
    // Source of the most recent pop or poll
    logic                               last_fifo;
    converge_pkg::stream_op_e           next_op;

    ///////////////////////////////
    // Pause, pop or poll
    ///////////////////////////////

    // No select and no pop while in reset
    assign stall = reset || resend_i || resend_q;
    assign pop_o = !stall && !fifo_empty_i;
    assign poll = !stall && fifo_empty_i;

    always_comb begin
        sel_one = '0;
        sel_one[poll_ptr] = 1'b1;
        outport_sel_o = poll ? sel_one : '0;
    end

    // Resend phase takes precedence over the source choice
    always_comb begin
        if (resend_i && !resend_q) begin
            next_op = last_fifo ? converge_pkg::OP_CAPTURE_FIFO : converge_pkg::OP_CAPTURE_PORT;
        end else if (resend_i) begin
            next_op = converge_pkg::OP_HOLD;
        end else if (resend_q) begin
            next_op = converge_pkg::OP_RELEASE;
        end else if (pop_o) begin
            next_op = converge_pkg::OP_PASS_FIFO;
        end else begin
            next_op = converge_pkg::OP_PASS_PORT;
        end
    end

    ///////////////////////////////
    // State
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            resend_q <= 1'b0;
            poll_ptr <= '0;
            last_fifo <= 1'b0;
            cmd_o.op <= converge_pkg::OP_IDLE;
            cmd_o.port <= '0;
        end else begin
            resend_q <= resend_i;
            cmd_o.op <= next_op;
            if (pop_o) begin
                last_fifo <= 1'b1;
            end
            if (poll) begin
                last_fifo <= 1'b0;
                // Port field keeps the last polled index while paused
                cmd_o.port <= poll_ptr;
                if (poll_ptr == converge_pkg::LAST_PORT) begin
                    poll_ptr <= '0;
                end else begin
                    poll_ptr <= poll_ptr + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/stream_result.sv ====
`timescale 1ns/100ps

module stream_result (
    input  logic                      clk,
    input  logic                      reset,
    input  converge_pkg::stream_cmd_t cmd_i,
    input  converge_pkg::packet_t     fifo_data_i,
    input  converge_pkg::packet_t     out_packets_i [converge_pkg::NUM_PORTS],
    output converge_pkg::packet_t     stream_o
);

    converge_pkg::packet_t src_pkt;
    // Word kept while downstream asks for a resend
    converge_pkg::packet_t hold_buf;
    logic                  use_fifo;

    ///////////////////////////////
    // Source select
    ///////////////////////////////

    always_comb begin
        use_fifo = (cmd_i.op == converge_pkg::OP_PASS_FIFO)
                || (cmd_i.op == converge_pkg::OP_CAPTURE_FIFO);
        if (use_fifo) begin
            src_pkt = fifo_data_i;
        end else begin
            src_pkt = out_packets_i[cmd_i.port];
        end
    end

    ///////////////////////////////
    // Stream and hold buffer
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stream_o <= '0;
            hold_buf <= '0;
        end else begin
            case (cmd_i.op)
                converge_pkg::OP_PASS_FIFO,
                converge_pkg::OP_PASS_PORT: begin
                    stream_o <= src_pkt;
                end
                converge_pkg::OP_CAPTURE_FIFO,
                converge_pkg::OP_CAPTURE_PORT: begin
                    // Stream stays frozen on capture
                    hold_buf <= src_pkt;
                end
                converge_pkg::OP_RELEASE: begin
                    stream_o <= hold_buf;
                    hold_buf <= '0;
                end
                default: begin
                    // Idle and hold leave both registers alone
                end
            endcase
        end
    end

endmodule

// ==== logic/converge_ctrl.sv ====
`timescale 1ns/100ps

module converge_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [converge_pkg::NUM_PORTS-1:0] freespace_update_i,
    input  converge_pkg::packet_t              in_packets_i [converge_pkg::NUM_PORTS],
    input  converge_pkg::packet_t              out_packets_i [converge_pkg::NUM_PORTS],
    input  logic                               resend_i,
    output logic [converge_pkg::NUM_PORTS-1:0] outport_sel_o,
    output converge_pkg::packet_t              stream_o
);

    converge_pkg::fifo_wr_t    fifo_wr;
    logic                      fifo_empty;
    logic                      fifo_pop;
    converge_pkg::packet_t     fifo_rd_data;
    converge_pkg::stream_cmd_t stream_cmd;

    ///////////////////////////////
    // Decode
    ///////////////////////////////

    update_decode u_decode (
        .clk                (clk),
        .reset              (reset),
        .freespace_update_i (freespace_update_i),
        .in_packets_i       (in_packets_i),
        .fifo_wr_o          (fifo_wr)
    );

    update_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .wr_i      (fifo_wr),
        .pop_i     (fifo_pop),
        .empty_o   (fifo_empty),
        .rd_data_o (fifo_rd_data)
    );

    ///////////////////////////////
    // Execute
    ///////////////////////////////

    converge_execute u_execute (
        .clk           (clk),
        .reset         (reset),
        .resend_i      (resend_i),
        .fifo_empty_i  (fifo_empty),
        .pop_o         (fifo_pop),
        .outport_sel_o (outport_sel_o),
        .cmd_o         (stream_cmd)
    );

    ///////////////////////////////
    // Result
    ///////////////////////////////

    stream_result u_result (
        .clk           (clk),
        .reset         (reset),
        .cmd_i         (stream_cmd),
        .fifo_data_i   (fifo_rd_data),
        .out_packets_i (out_packets_i),
        .stream_o      (stream_o)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #2 clk_o = ~clk_o;
    end

endmodule

// ==== testbench/tb_converge_ctrl.sv ====
`timescale 1ns/100ps

module tb_converge_ctrl;

    typedef struct packed {
        logic [7:0]                         cycles;
        logic [converge_pkg::NUM_PORTS-1:0] strobe;
        logic [converge_pkg::NUM_PORTS-1:0] valid_mask;
        logic                               resend;
    } row_t;

    // What the stream register does on the next edge
    typedef enum {ACT_NONE, ACT_LOAD, ACT_CAPTURE, ACT_RELEASE} act_e;

    logic                               clk;
    logic                               reset;
    logic [converge_pkg::NUM_PORTS-1:0] freespace_update;
    converge_pkg::packet_t              in_packets [converge_pkg::NUM_PORTS];
    converge_pkg::packet_t              out_packets [converge_pkg::NUM_PORTS];
    logic                               resend;
    logic [converge_pkg::NUM_PORTS-1:0] outport_sel;
    converge_pkg::packet_t              stream;

    row_t   rows [$];
    string  row_names [$];
    integer seed;
    int     cycle_count;
    int     cycle_limit;
    int     row_errors;
    int     pass_rows;
    int     fail_rows;

    // Port buffer model
    logic [converge_pkg::NUM_PORTS-1:0] prev_sel;
    int                                 buf_seq [converge_pkg::NUM_PORTS];

    // Reference model state
    logic [converge_pkg::NUM_PORTS-1:0] m_strobe_q;
    converge_pkg::packet_t              m_slots [converge_pkg::NUM_PORTS];
    converge_pkg::packet_t              m_queue [$];
    int                                 m_scan;
    int                                 m_poll;
    int                                 m_seq [converge_pkg::NUM_PORTS];
    logic                               m_resend_q;
    logic                               m_pop;
    logic                               m_polled;
    logic [converge_pkg::NUM_PORTS-1:0] m_sel;
    converge_pkg::packet_t              m_last_src;
    converge_pkg::packet_t              m_stream;
    converge_pkg::packet_t              m_hold;
    act_e                               m_action;

    tb_clock u_clock (
        .clk_o (clk)
    );

    converge_ctrl DUT (
        .clk                (clk),
        .reset              (reset),
        .freespace_update_i (freespace_update),
        .in_packets_i       (in_packets),
        .out_packets_i      (out_packets),
        .resend_i           (resend),
        .outport_sel_o      (outport_sel),
        .stream_o           (stream)
    );

    ///////////////////////////////
    // Helpers
    ///////////////////////////////

    function automatic converge_pkg::packet_t data_packet(input int port, input int seq_num);
        converge_pkg::packet_t p;
        p.valid = 1'b1;
        p.kind = converge_pkg::KIND_DATA;
        p.src_port = port[converge_pkg::SRC_PORT_BITS-1:0];
        p.payload = seq_num[converge_pkg::PAYLOAD_BITS-1:0];
        return p;
    endfunction

    task automatic add_row(input string name, input int cycles,
                           input logic [converge_pkg::NUM_PORTS-1:0] strobe_lvl,
                           input logic [converge_pkg::NUM_PORTS-1:0] valid_mask,
                           input logic resend_lvl);
        row_t r;
        r.cycles = cycles[7:0];
        r.strobe = strobe_lvl;
        r.valid_mask = valid_mask;
        r.resend = resend_lvl;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // Fresh update packets for each row, valid bit from the mask
    task automatic load_row_packets(input row_t r);
        converge_pkg::packet_t p;
        integer                rnd;
        for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
            rnd = $random(seed);
            p.valid = r.valid_mask[i];
            p.kind = converge_pkg::KIND_FREESPACE;
            p.src_port = i[converge_pkg::SRC_PORT_BITS-1:0];
            p.payload = rnd[converge_pkg::PAYLOAD_BITS-1:0];
            in_packets[i] = p;
        end
    endtask

    task automatic report_row(input string name, input int cycles);
        if (row_errors == 0) begin
            pass_rows++;
            $display("test %s: ok after %0d cycles", name, cycles);
        end else begin
            fail_rows++;
            $display("test %s: %0d errors in %0d cycles", name, row_errors, cycles);
        end
    endtask

    ///////////////////////////////
    // Reference model
    ///////////////////////////////

    task automatic model_reset();
        m_strobe_q = '0;
        m_queue.delete();
        m_scan = 0;
        m_poll = 0;
        m_resend_q = 1'b0;
        m_last_src = '0;
        m_stream = '0;
        m_hold = '0;
        m_action = ACT_NONE;
        for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
            m_slots[i] = '0;
            m_seq[i] = 0;
            buf_seq[i] = 0;
        end
    endtask

    // Pause, pop or poll for the current cycle
    task automatic model_outputs(input logic resend_lvl);
        logic stall;
        stall = resend_lvl || m_resend_q;
        m_pop = !stall && (m_queue.size() != 0);
        m_polled = !stall && !m_pop;
        m_sel = '0;
        if (m_polled) begin
            m_sel[m_poll] = 1'b1;
        end
    endtask

    task automatic model_step(input logic [converge_pkg::NUM_PORTS-1:0] strobe_lvl,
                              input logic resend_lvl);
        logic [converge_pkg::NUM_PORTS-1:0] rise;
        converge_pkg::packet_t              wr_pkt;
        logic                               wr_en;
        // Stream acts on the source chosen one cycle earlier
        case (m_action)
            ACT_LOAD: m_stream = m_last_src;
            ACT_CAPTURE: m_hold = m_last_src;
            ACT_RELEASE: begin
                m_stream = m_hold;
                m_hold = '0;
            end
            default: begin
            end
        endcase
        if (resend_lvl && !m_resend_q) begin
            m_action = ACT_CAPTURE;
        end else if (resend_lvl) begin
            m_action = ACT_NONE;
        end else if (m_resend_q) begin
            m_action = ACT_RELEASE;
        end else begin
            m_action = ACT_LOAD;
        end
        if (m_pop) begin
            m_last_src = m_queue.pop_front();
        end else if (m_polled) begin
            m_last_src = data_packet(m_poll, m_seq[m_poll]);
            m_seq[m_poll]++;
            m_poll = (m_poll + 1) % converge_pkg::NUM_PORTS;
        end
        // Scan write leaves first, a new edge then reloads its slot
        wr_en = m_slots[m_scan].valid;
        wr_pkt = m_slots[m_scan];
        if (wr_en) begin
            m_slots[m_scan] = '0;
        end
        rise = strobe_lvl & ~m_strobe_q;
        for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
            if (rise[i]) begin
                m_slots[i] = in_packets[i];
            end
        end
        if (wr_en) begin
            m_queue.push_back(wr_pkt);
        end
        m_scan = (m_scan + 1) % converge_pkg::NUM_PORTS;
        m_strobe_q = strobe_lvl;
        m_resend_q = resend_lvl;
    endtask

    ///////////////////////////////
    // One clock cycle
    ///////////////////////////////

    task automatic run_cycle(input row_t r, input string name);
        // Buffers present the packet of the previous select
        for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
            if (prev_sel[i]) begin
                out_packets[i] = data_packet(i, buf_seq[i]);
                buf_seq[i]++;
            end
        end
        freespace_update = r.strobe;
        resend = r.resend;
        model_outputs(r.resend);
        #1;
        assert (outport_sel === m_sel) else begin
            $display("CHECK FAILED %s outport_sel_o expected %b actual %b",
                     name, m_sel, outport_sel);
            row_errors++;
        end
        assert (stream === m_stream) else begin
            $display("CHECK FAILED %s stream_o expected %h actual %h", name, m_stream, stream);
            row_errors++;
        end
        prev_sel = outport_sel;
        model_step(r.strobe, r.resend);
        @(negedge clk);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seed = 40571;
        cycle_count = 0;
        pass_rows = 0;
        fail_rows = 0;
        reset = 1'b1;
        resend = 1'b0;
        freespace_update = '0;
        prev_sel = '0;
        for (int i = 0; i < converge_pkg::NUM_PORTS; i++) begin
            in_packets[i] = '0;
            out_packets[i] = '0;
        end

        add_row("reset_poll",          16, 7'b0000000, 7'b1111111, 1'b0);
        add_row("single_edge",          1, 7'b0000100, 7'b1111111, 1'b0);
        add_row("single_drain",        14, 7'b0000000, 7'b1111111, 1'b0);
        add_row("multi_edge",           1, 7'b1011010, 7'b1110111, 1'b0);
        add_row("multi_held",           6, 7'b1011010, 7'b1110111, 1'b0);
        add_row("multi_drain",         16, 7'b0000000, 7'b1111111, 1'b0);
        add_row("resend_pulse",         5, 7'b0000000, 7'b1111111, 1'b1);
        add_row("resend_release",      16, 7'b0000000, 7'b1111111, 1'b0);
        add_row("edge_in_resend",       1, 7'b0100000, 7'b1111111, 1'b1);
        add_row("resend_hold",          4, 7'b0000000, 7'b1111111, 1'b1);
        add_row("resend_update_drain", 16, 7'b0000000, 7'b1111111, 1'b0);
        add_row("overwrite_first",      1, 7'b0100000, 7'b1111111, 1'b0);
        add_row("overwrite_gap",        1, 7'b0000000, 7'b1111111, 1'b0);
        add_row("overwrite_second",     1, 7'b0100000, 7'b1111111, 1'b0);
        add_row("overwrite_drain",     16, 7'b0000000, 7'b1111111, 1'b0);
        // Resend right after a pop keeps the FIFO word
        add_row("pop_edge",             1, 7'b0010000, 7'b1111111, 1'b0);
        add_row("pop_wait",             2, 7'b0000000, 7'b1111111, 1'b0);
        add_row("pop_resend",           3, 7'b0000000, 7'b1111111, 1'b1);
        add_row("pop_release",         12, 7'b0000000, 7'b1111111, 1'b0);

        cycle_limit = 50;
        foreach (rows[i]) begin
            cycle_limit += rows[i].cycles;
        end
        model_reset();

        repeat (5) @(negedge clk);
        row_errors = 0;
        assert (outport_sel === '0) else begin
            $display("CHECK FAILED reset outport_sel_o expected 0 actual %b", outport_sel);
            row_errors++;
        end
        assert (stream === '0) else begin
            $display("CHECK FAILED reset stream_o expected 0 actual %h", stream);
            row_errors++;
        end
        report_row("reset", 5);
        reset = 1'b0;

        foreach (rows[r]) begin
            row_errors = 0;
            load_row_packets(rows[r]);
            for (int c = 0; c < rows[r].cycles; c++) begin
                run_cycle(rows[r], row_names[r]);
            end
            report_row(row_names[r], rows[r].cycles);
        end

        $display("Tests passed: %0d, failed: %0d", pass_rows, fail_rows);
        if (fail_rows == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/converge_pkg.sv
logic/update_decode.sv
logic/update_fifo.sv
logic/converge_execute.sv
logic/stream_result.sv
logic/converge_ctrl.sv
testbench/tb_clock.sv
testbench/tb_converge_ctrl.sv

// ==== Bender.yml ====
package:
  name: converge_ctrl

sources:
  # RTL
  - files:
      - logic/converge_pkg.sv
      - logic/update_decode.sv
      - logic/update_fifo.sv
      - logic/converge_execute.sv
      - logic/stream_result.sv
      - logic/converge_ctrl.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_converge_ctrl.sv
